//--- all.f
verilog/ledger_pkg.sv
verilog/txn_if.sv
verilog/lfsr_table.sv
verilog/main_control.sv
verilog/transaction_control.sv
verilog/memory_control.sv
verilog/datapath.sv
verilog/ledger_top.sv
test/ledger_assert.sv
test/tb_ledger.sv

//--- Bender.yml
package:
  name: ledger

sources:
  - verilog/ledger_pkg.sv
  - verilog/txn_if.sv
  - verilog/lfsr_table.sv
  - verilog/main_control.sv
  - verilog/transaction_control.sv
  - verilog/memory_control.sv
  - verilog/datapath.sv
  - verilog/ledger_top.sv
  - target: test
    files:
      - test/ledger_assert.sv
      - test/tb_ledger.sv

//--- test/tb_ledger.sv
// Expects ACCT_W 24 and TABLE_N 8; the key table is predicted by a software LFSR model
`default_nettype none
`timescale 1ns/10ps

module tb_ledger;
	import ledger_pkg::*;

	localparam int          ACCT_W        = 24;
	localparam int unsigned START_BALANCE = 1000;
	localparam int          TABLE_N       = 8;
	localparam int          NUM_TESTS     = 12;
	localparam int          QUIET_CYCLES  = 4; // Watch window after an ignored start
	localparam int          CYCLE_LIMIT   = 64 * NUM_TESTS + TABLE_N + 16;

	typedef enum logic [1:0] {KEY_GOOD, KEY_BAD, KEY_NONE} key_mode_t;

	typedef struct {
		string      name;
		logic [7:0] amount;
		key_mode_t  mode;
		logic       exp_accept;
	} test_row_t;

	logic              clock;
	logic              arst_n;
	logic              start;
	logic              load;
	logic [7:0]        switches;
	logic [ACCT_W-1:0] balance_a;
	logic [ACCT_W-1:0] balance_b;
	logic              ready;
	logic              busy;
	logic              accepted;
	logic              rejected;

	test_row_t         tests [NUM_TESTS];
	logic [7:0]        key_model [TABLE_N];
	logic [ACCT_W-1:0] model_a;
	logic [ACCT_W-1:0] model_b;
	logic              model_acc;
	logic              model_rej;
	int                cycle_count;
	int                errors;
	int                test_errors;
	int                tests_run;
	int                tests_failed;

	ledger_top #(.ACCT_W(ACCT_W), .START_BALANCE(START_BALANCE), .TABLE_N(TABLE_N)) dut (
		.clock(clock), .arst_n(arst_n), .start(start), .load(load), .switches(switches),
		.balance_a(balance_a), .balance_b(balance_b), .ready(ready), .busy(busy),
		.accepted(accepted), .rejected(rejected));

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic fill_tests();
		tests[0]  = '{"good_small", 8'd37, KEY_GOOD, 1'b1};
		tests[1]  = '{"wrong_key", 8'd20, KEY_BAD, 1'b0};
		tests[2]  = '{"big_1", 8'd255, KEY_GOOD, 1'b1};
		tests[3]  = '{"big_2", 8'd255, KEY_GOOD, 1'b1};
		tests[4]  = '{"big_3", 8'd255, KEY_GOOD, 1'b1};
		tests[5]  = '{"overdraw", 8'd200, KEY_GOOD, 1'b0}; // A holds 198 here
		tests[6]  = '{"start_no_load", 8'd0, KEY_NONE, 1'b0};
		tests[7]  = '{"drain", 8'd198, KEY_GOOD, 1'b1};
		tests[8]  = '{"empty_wrong", 8'd1, KEY_BAD, 1'b0};
		tests[9]  = '{"empty_good", 8'd1, KEY_GOOD, 1'b0};
		tests[10] = '{"zero_amount", 8'd0, KEY_GOOD, 1'b1};
		tests[11] = '{"start_no_load_2", 8'd0, KEY_NONE, 1'b1};
	endtask

	// Galois shift with taps applied when a one falls out
	task automatic build_key_model();
		logic [15:0] state;
		logic        lsb;
		state = LFSR_SEED;
		for (int i = 0; i < TABLE_N; i++)
		begin
			lsb   = state[0];
			state = state >> 1;
			if (lsb)
				state = state ^ LFSR_TAPS;
			key_model[i] = state[7:0];
		end
	endtask

	task automatic report_mismatch(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
		errors++;
		test_errors++;
	endtask

	task automatic pulse_load(input logic [7:0] value);
		@(posedge clock);
		switches <= value;
		load     <= 1'b1;
		@(posedge clock);
		load     <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic wait_for_ready();
		@(negedge clock);
		while (ready !== 1'b1)
			@(negedge clock);
	endtask

	task automatic wait_for_busy();
		@(negedge clock);
		while (busy !== 1'b1)
			@(negedge clock);
	endtask

	task automatic check_outputs(input string test_name, input logic exp_acc,
		input logic exp_rej);
		if (accepted !== exp_acc)
			report_mismatch(test_name, "accepted", exp_acc, accepted);
		if (rejected !== exp_rej)
			report_mismatch(test_name, "rejected", exp_rej, rejected);
		if (balance_a !== model_a)
			report_mismatch(test_name, "balance_a", model_a, balance_a);
		if (balance_b !== model_b)
			report_mismatch(test_name, "balance_b", model_b, balance_b);
		tests_run++;
		if (test_errors == 0)
			$display("test %s ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d mismatches", test_name, test_errors);
		end
	endtask

	task automatic run_row(input test_row_t row);
		logic [7:0] key;
		logic       saw_busy;
		logic       exp_acc;
		logic       exp_rej;
		key         = key_model[row.amount % TABLE_N];
		saw_busy    = 1'b0;
		test_errors = 0;
		if (row.mode == KEY_BAD)
			key = key ^ 8'h5A;
		if (row.mode == KEY_NONE)
		begin
			pulse_start();
			repeat (QUIET_CYCLES)
			begin
				@(negedge clock);
				if (busy !== 1'b0)
					saw_busy = 1'b1;
			end
			if (saw_busy)
			begin
				$display("%s: busy went high after a start with no loads", row.name);
				errors++;
				test_errors++;
			end
			exp_acc = model_acc; // Flags must hold their last values
			exp_rej = model_rej;
		end
		else
		begin
			pulse_load(row.amount);
			pulse_load(key);
			pulse_start();
			wait_for_busy();
			wait_for_ready();
			// Transfer needs the right key and enough in A
			if (row.mode == KEY_GOOD && row.amount <= model_a)
			begin
				model_a = model_a - row.amount;
				model_b = model_b + row.amount;
			end
			exp_acc = row.exp_accept;
			exp_rej = !row.exp_accept;
		end
		check_outputs(row.name, exp_acc, exp_rej);
		model_acc = exp_acc;
		model_rej = exp_rej;
	endtask

	initial
	begin
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		arst_n       = 1'b0;
		start        = 1'b0;
		load         = 1'b0;
		switches     = 8'h00;
		model_a      = ACCT_W'(START_BALANCE);
		model_b      = ACCT_W'(START_BALANCE);
		model_acc    = 1'b0;
		model_rej    = 1'b0;
		fill_tests();
		build_key_model();
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;

		// Table fill and ledger init
		test_errors = 0;
		wait_for_ready();
		check_outputs("init", 1'b0, 1'b0);

		for (int t = 0; t < NUM_TESTS; t++)
			run_row(tests[t]);

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/ledger_assert.sv
// Bound into ledger_top; the sum check holds only because transfers move value from A to B
`default_nettype none
`timescale 1ns/10ps

module ledger_assert #(
	parameter int          ACCT_W        = 24,
	parameter int unsigned START_BALANCE = 1000
) (
	input logic              clock,
	input logic              arst_n,
	input logic              ready,
	input logic              busy,
	input logic              start_transaction,
	input logic              finished_init,
	input ledger_pkg::step_t step,
	input logic [ACCT_W-1:0] balance_a,
	input logic [ACCT_W-1:0] balance_b
);
	import ledger_pkg::*;

	localparam logic [ACCT_W:0] TOTAL = (ACCT_W + 1)'(2 * START_BALANCE);

	logic [ACCT_W:0] sum; // One extra bit so the sum cannot wrap
	assign sum = balance_a + balance_b;

	a_ready_busy: assert property (@(posedge clock) disable iff (!arst_n) !(ready && busy))
		else $error("ready and busy are high together");

	a_balance_sum: assert property (@(posedge clock) disable iff (!arst_n)
		finished_init |-> (sum == TOTAL))
		else $error("balance_a + balance_b left the starting total");

	// Sequencer must be back in idle before the next start
	a_start_ready: assert property (@(posedge clock) disable iff (!arst_n)
		start_transaction |-> (ready && step == STEP_IDLE))
		else $error("start_transaction issued while not ready or with the sequencer active");

endmodule

bind ledger_top ledger_assert #(.ACCT_W(ACCT_W), .START_BALANCE(START_BALANCE)) u_ledger_assert (
	.clock(clock), .arst_n(arst_n), .ready(ready), .busy(busy),
	.start_transaction(start_transaction), .finished_init(finished_init),
	.step(txn.step), .balance_a(balance_a), .balance_b(balance_b));

`default_nettype wire

//--- verilog/ledger_top.sv
// Two-account ledger top; switches carry both amount and key, pulses must be one cycle
`default_nettype none
`timescale 1ns/10ps

module ledger_top #(
	parameter int          ACCT_W        = 24,
	parameter int unsigned START_BALANCE = 1000,
	parameter int          TABLE_N       = 8
) (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              start,
	input  logic              load,
	input  logic [7:0]        switches,
	output logic [ACCT_W-1:0] balance_a,
	output logic [ACCT_W-1:0] balance_b,
	output logic              ready,
	output logic              busy,
	output logic              accepted,
	output logic              rejected
);

	logic       random_init;
	logic       table_done;
	logic       init_memory;
	logic       finished_init;
	logic       load_amount;
	logic       load_key;
	logic       start_transaction;
	logic       finished;
	logic [7:0] key_table [TABLE_N];

	txn_if #(.ACCT_W(ACCT_W)) txn ();

	lfsr_table #(.TABLE_N(TABLE_N)) u_lfsr_table (.clock(clock), .arst_n(arst_n),
		.enable(random_init), .table_done(table_done), .key_table(key_table));

	main_control u_main_control (.clock(clock), .arst_n(arst_n), .start(start), .load(load),
		.table_done(table_done), .finished_init(finished_init), .finished(finished),
		.random_init(random_init), .init_memory(init_memory), .load_amount(load_amount),
		.load_key(load_key), .start_transaction(start_transaction), .ready(ready), .busy(busy));

	transaction_control u_transaction_control (.clock(clock), .arst_n(arst_n),
		.start_transaction(start_transaction), .finished(finished), .bus(txn.sequencer));

	memory_control #(.ACCT_W(ACCT_W), .START_BALANCE(START_BALANCE)) u_memory_control (
		.clock(clock), .arst_n(arst_n), .init_memory(init_memory),
		.finished_init(finished_init), .balance_a(balance_a), .balance_b(balance_b),
		.bus(txn.memory));

	datapath #(.ACCT_W(ACCT_W), .TABLE_N(TABLE_N)) u_datapath (.clock(clock), .arst_n(arst_n),
		.amount_in(switches), .load_amount(load_amount), .load_key(load_key),
		.key_table(key_table), .accepted(accepted), .rejected(rejected), .bus(txn.datapath));

endmodule

`default_nettype wire

//--- verilog/datapath.sv
// Key and funds check; amount low log2(TABLE_N) bits pick the key, ACCT_W must exceed 8
`default_nettype none
`timescale 1ns/10ps

module datapath #(
	parameter int ACCT_W  = 24,
	parameter int TABLE_N = 8
) (
	input  logic       clock,
	input  logic       arst_n,
	input  logic [7:0] amount_in,
	input  logic       load_amount,
	input  logic       load_key,
	input  logic [7:0] key_table [TABLE_N],
	output logic       accepted,
	output logic       rejected,
	txn_if.datapath    bus
);
	import ledger_pkg::*;

	localparam int IDX_W = $clog2(TABLE_N);

	logic [7:0]        amount_q;
	logic [7:0]        key_q;
	ledger_word_t      word_q;
	ledger_word_t      result_q;
	logic              key_ok_q;
	logic              funds_ok_q;
	step_t             done_step_q; // Last step that has completed
	logic [ACCT_W-1:0] amount_ext;
	logic [7:0]        table_key;
	logic              transfer_ok;
	logic              check_now;
	logic              update_now;

	assign amount_ext  = {{(ACCT_W - 8){1'b0}}, amount_q};
	assign table_key   = key_table[amount_q[IDX_W-1:0]];
	assign transfer_ok = key_ok_q && funds_ok_q;
	assign check_now   = (bus.step == STEP_CHECK) && (done_step_q != STEP_CHECK);
	assign update_now  = (bus.step == STEP_UPDATE) && (done_step_q != STEP_UPDATE);

	always_ff @(posedge clock)
	begin
		if (load_amount)
			amount_q <= amount_in;
		if (load_key)
			key_q <= amount_in; // Same switches as the amount
		if (bus.load_registers)
			word_q <= bus.ledger;
		if (update_now)
		begin
			if (transfer_ok)
			begin
				result_q.bal_a <= word_q.bal_a - amount_ext;
				result_q.bal_b <= word_q.bal_b + amount_ext;
			end
			else
				result_q <= word_q;
		end
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			done_step_q <= STEP_IDLE;
			key_ok_q    <= 1'b0;
			funds_ok_q  <= 1'b0;
			accepted    <= 1'b0;
			rejected    <= 1'b0;
		end
		else if (check_now)
		begin
			key_ok_q    <= (key_q == table_key);
			funds_ok_q  <= (amount_ext <= word_q.bal_a); // A must cover it
			done_step_q <= STEP_CHECK;
		end
		else if (update_now)
		begin
			accepted    <= transfer_ok;
			rejected    <= !transfer_ok;
			done_step_q <= STEP_UPDATE;
		end
		else if (bus.step == STEP_LOAD)
		begin
			accepted    <= 1'b0; // New transaction clears the flags
			rejected    <= 1'b0;
			done_step_q <= STEP_IDLE;
		end
		else if (bus.step != STEP_CHECK && bus.step != STEP_UPDATE)
			done_step_q <= STEP_IDLE;
	end

	// High only while the finished step is still current
	assign bus.data_done = (bus.step == STEP_CHECK || bus.step == STEP_UPDATE)
		&& (done_step_q == bus.step);
	assign bus.result    = result_q;

endmodule

`default_nettype wire

//--- verilog/memory_control.sv
// Ledger storage; balances are undefined until the first init_memory pulse
`default_nettype none
`timescale 1ns/10ps

module memory_control #(
	parameter int          ACCT_W        = 24,
	parameter int unsigned START_BALANCE = 1000
) (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              init_memory,
	output logic              finished_init,
	output logic [ACCT_W-1:0] balance_a,
	output logic [ACCT_W-1:0] balance_b,
	txn_if.memory             bus
);
	import ledger_pkg::*;

	localparam logic [ACCT_W-1:0] START_VALUE = ACCT_W'(START_BALANCE);

	ledger_word_t ledger_q;
	logic         store_done_q;
	logic         write_en;

	assign write_en = (bus.step == STEP_STORE) && !store_done_q; // First STORE cycle

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			finished_init <= 1'b0;
			store_done_q  <= 1'b0;
		end
		else
		begin
			if (init_memory)
				finished_init <= 1'b1;
			store_done_q <= write_en; // Pulse the cycle after the write
		end
	end

	always_ff @(posedge clock)
	begin
		if (init_memory)
		begin
			ledger_q.bal_a <= START_VALUE;
			ledger_q.bal_b <= START_VALUE;
		end
		else if (write_en)
			ledger_q <= bus.result;
	end

	// STEP_LOAD lasts one cycle, so this is a pulse
	assign bus.load_registers = (bus.step == STEP_LOAD);
	assign bus.store_done     = store_done_q;
	assign bus.ledger         = ledger_q;

	assign balance_a = ledger_q.bal_a;
	assign balance_b = ledger_q.bal_b;

endmodule

`default_nettype wire

//--- verilog/transaction_control.sv
// Step sequencer; each step waits on its own done source with no time limit
`default_nettype none
`timescale 1ns/10ps

module transaction_control (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        start_transaction,
	output logic        finished,
	txn_if.sequencer    bus
);
	import ledger_pkg::*;

	step_t step_q;
	logic  step_done;

	// Done source per step
	always_comb
	begin
		case (step_q)
			STEP_LOAD:   step_done = bus.load_registers;
			STEP_CHECK:  step_done = bus.data_done;
			STEP_UPDATE: step_done = bus.data_done;
			STEP_STORE:  step_done = bus.store_done;
			default:     step_done = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			step_q <= STEP_IDLE;
		else
		begin
			case (step_q)
				STEP_IDLE:   if (start_transaction) step_q <= STEP_LOAD;
				STEP_LOAD:   if (step_done) step_q <= STEP_CHECK;
				STEP_CHECK:  if (step_done) step_q <= STEP_UPDATE;
				STEP_UPDATE: if (step_done) step_q <= STEP_STORE;
				STEP_STORE:  if (step_done) step_q <= STEP_IDLE;
				default:     step_q <= STEP_IDLE;
			endcase
		end
	end

	assign bus.step = step_q;
	assign finished = (step_q == STEP_STORE) && step_done; // Leaving STORE

endmodule

`default_nettype wire

//--- verilog/main_control.sv
// Top FSM; start and load are expected as clean one-cycle pulses synchronous to clock
`default_nettype none
`timescale 1ns/10ps

module main_control (
	input  logic clock,
	input  logic arst_n,
	input  logic start,
	input  logic load,
	input  logic table_done,
	input  logic finished_init,
	input  logic finished,
	output logic random_init,
	output logic init_memory,
	output logic load_amount,
	output logic load_key,
	output logic start_transaction,
	output logic ready,
	output logic busy
);

	typedef enum logic [2:0]
	{
		INIT_TABLE,
		INIT_MEM,
		WAIT_AMOUNT,
		WAIT_KEY,
		WAIT_START,
		TRANSACT
	} state_t;

	state_t state_q;
	state_t state_d;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			INIT_TABLE:  if (table_done) state_d = INIT_MEM;
			INIT_MEM:    if (finished_init) state_d = WAIT_AMOUNT;
			WAIT_AMOUNT: if (load) state_d = WAIT_KEY;
			WAIT_KEY:    if (load) state_d = WAIT_START;
			WAIT_START:
			begin
				if (start)
					state_d = TRANSACT;
				else if (load)
					state_d = WAIT_KEY; // New amount, key needed again
			end
			TRANSACT:    if (finished) state_d = WAIT_AMOUNT;
			default:     state_d = INIT_TABLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			state_q <= INIT_TABLE;
		else
			state_q <= state_d;
	end

	assign random_init = (state_q == INIT_TABLE);
	assign init_memory = (state_q == INIT_MEM) && !finished_init; // Single cycle

	// Load pulses go to the amount or the key in turn
	assign load_amount = load && (state_q == WAIT_AMOUNT || state_q == WAIT_START);
	assign load_key    = load && (state_q == WAIT_KEY);

	assign start_transaction = start && (state_q == WAIT_START);

	assign ready = (state_q == WAIT_AMOUNT) || (state_q == WAIT_KEY) || (state_q == WAIT_START);
	assign busy  = (state_q == TRANSACT);

endmodule

`default_nettype wire

//--- verilog/lfsr_table.sv
// Fills TABLE_N keys once after reset; TABLE_N must be a power of two and at least 2
`default_nettype none
`timescale 1ns/10ps

module lfsr_table #(
	parameter int TABLE_N = 8
) (
	input  logic       clock,
	input  logic       arst_n,
	input  logic       enable,
	output logic       table_done,
	output logic [7:0] key_table [TABLE_N]
);
	import ledger_pkg::*;

	localparam int               IDX_W    = $clog2(TABLE_N);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(TABLE_N - 1);

	logic [15:0]      lfsr_q;
	logic [15:0]      lfsr_next;
	logic [IDX_W-1:0] idx_q;
	logic             fill;

	// Right shift, taps folded in when a one drops out
	assign lfsr_next = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 16'h0000);
	assign fill      = enable && !table_done;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			lfsr_q     <= LFSR_SEED;
			idx_q      <= '0;
			table_done <= 1'b0;
		end
		else if (fill)
		begin
			lfsr_q <= lfsr_next;
			idx_q  <= idx_q + 1'b1;
			if (idx_q == LAST_IDX)
				table_done <= 1'b1; // Last entry written, stop
		end
	end

	always_ff @(posedge clock)
	begin
		if (fill)
			key_table[idx_q] <= lfsr_next[7:0]; // Low byte of the new state
	end

endmodule

`default_nettype wire

//--- verilog/txn_if.sv
// Transaction step bus; ACCT_W must equal ledger_pkg::BAL_W or elaboration stops
`default_nettype none
`timescale 1ns/10ps

interface txn_if #(
	parameter int ACCT_W = 24
);
	import ledger_pkg::*;

	step_t        step;           // Current transaction phase
	logic         data_done;      // Check or update finished
	logic         store_done;     // Pulse after the ledger write
	logic         load_registers; // Pulse while the ledger word is offered
	ledger_word_t ledger;
	ledger_word_t result;

	// The shared word type cannot follow ACCT_W
	if (ACCT_W != BAL_W)
	begin : g_width_check
		$error("txn_if: ACCT_W differs from ledger_pkg::BAL_W");
	end

	modport sequencer (output step, input data_done, input store_done, input load_registers);
	modport datapath (input step, input load_registers, input ledger, output data_done,
		output result);
	modport memory (input step, input result, output ledger, output load_registers,
		output store_done);

endinterface

`default_nettype wire

//--- verilog/ledger_pkg.sv
// Balance width inside ledger_word_t is fixed by BAL_W, so every ACCT_W parameter must equal it
`default_nettype none

package ledger_pkg;

	localparam int BAL_W = 24;          // Bits per account balance

	// Transaction phases walked by the sequencer
	typedef enum logic [2:0]
	{
		STEP_IDLE   = 3'd0,
		STEP_LOAD   = 3'd1, // Datapath takes the ledger word
		STEP_CHECK  = 3'd2, // Key and funds check
		STEP_UPDATE = 3'd3, // New balances formed
		STEP_STORE  = 3'd4  // Ledger written back
	} step_t;

	typedef struct packed
	{
		logic [BAL_W-1:0] bal_a;
		logic [BAL_W-1:0] bal_b;
	} ledger_word_t;

	// Galois LFSR, x^16+x^14+x^13+x^11+1
	localparam logic [15:0] LFSR_SEED = 16'hACE1;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

endpackage

`default_nettype wire
